// File: hw/ex_pkg.sv
package ex_pkg;

  // Every word is handled as four 4-bit slices, least significant first.
  localparam int SLICES = 4;

  typedef logic [3:0]  slice_t;
  typedef logic [15:0] word_t;
  typedef logic [3:0]  reg_t;
  typedef logic [1:0]  ctr_t;
  typedef logic [7:0]  cond_t;
  typedef logic [3:0]  pins_t;

  // Register 0 is hardwired to zero.
  localparam reg_t REG_ZR = 4'h0;

  // Instruction classes.
  // Codes 0 and F are left free and execute as no-ops.
  typedef enum logic [3:0] {
    OP_ADD    = 4'h1,
    OP_SUB    = 4'h2,
    OP_AND    = 4'h3,
    OP_OR     = 4'h4,
    OP_XOR    = 4'h5,
    OP_CMPEQ  = 4'h6,
    OP_CMPNE  = 4'h7,
    OP_CMPLT  = 4'h8,
    OP_CMPLTU = 4'h9,
    OP_CMPGE  = 4'hA,
    OP_CMPGEU = 4'hB,
    OP_LDI    = 4'hC,
    OP_COND   = 4'hD,
    OP_PIN    = 4'hE
  } opcode_t;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR
  } alu_op_t;

  typedef enum logic [2:0] {
    CMP_EQ,
    CMP_NE,
    CMP_LT,
    CMP_LTU,
    CMP_GE,
    CMP_GEU
  } cmp_op_t;

  typedef enum logic [1:0] {
    PIN_IN,
    PIN_OUT,
    PIN_OUTN,
    PIN_OUTP
  } pin_op_t;

  // Register form with three register fields.
  typedef struct packed {
    opcode_t opcode;
    reg_t    dst;
    reg_t    lhs;
    reg_t    rhs;
  } r_form_t;

  // Immediate form.
  // LDI takes the byte as its value, COND as its mask and PIN as op and index.
  typedef struct packed {
    opcode_t    opcode;
    reg_t       dst;
    logic [7:0] imm;
  } i_form_t;

  // Both forms share the opcode and dst positions.
  typedef union packed {
    r_form_t r_form;
    i_form_t i_form;
  } instr_u;

endpackage

// File: hw/ex_decode.sv
module ex_decode (
  input  var logic             i_de_gck,
  input  var logic             i_de_rst_n,

  input  var ex_pkg::word_t    i_de_enc,
  input  var logic             i_de_enc_vld,
  output var logic             o_de_acp,
  output var ex_pkg::ctr_t     o_de_ctr,

  output var ex_pkg::alu_op_t  o_de_alu_op,
  output var ex_pkg::cmp_op_t  o_de_cmp_op,
  output var ex_pkg::pin_op_t  o_de_pin_op,
  output var logic [1:0]       o_de_pin_idx,

  output var ex_pkg::reg_t     o_de_dst,
  output var ex_pkg::reg_t     o_de_lhs,
  output var ex_pkg::reg_t     o_de_rhs,
  output var ex_pkg::slice_t   o_de_imm,

  output var logic             o_de_wr,
  output var logic             o_de_cmp,
  output var logic             o_de_cond_wr,
  output var logic             o_de_pin,
  output var ex_pkg::cond_t    o_de_cond_mask
);

  import ex_pkg::*;

  ctr_t   ctr_q;
  instr_u instr_q;
  logic   vld_q;
  logic   is_ldi;

  // The slice counter free-runs from reset.
  // Each pass through 0..3 is one instruction window.
  always_ff @(posedge i_de_gck, negedge i_de_rst_n) begin
    if (!i_de_rst_n) begin
      ctr_q <= '0;
    end
    else begin
      ctr_q <= ctr_q + 2'd1;
    end
  end

  // A new encoding is accepted only on the final slice of a window.
  always_comb o_de_acp = &ctr_q;
  always_comb o_de_ctr = ctr_q;

  // Capture the encoding for the coming window.
  // A missing valid flag leaves a bubble.
  always_ff @(posedge i_de_gck, negedge i_de_rst_n) begin
    if (!i_de_rst_n) begin
      vld_q <= 1'b0;
    end
    else if (o_de_acp) begin
      vld_q <= i_de_enc_vld;
    end
  end

  always_ff @(posedge i_de_gck) begin
    if (o_de_acp) begin
      instr_q <= i_de_enc;
    end
  end

  // Compares run as a subtract so the flags carry the result.
  // LDI runs as an OR of two zero registers so the ALU stays quiet.
  always_comb begin
    case (instr_q.r_form.opcode)
      OP_AND:  o_de_alu_op = ALU_AND;
      OP_OR:   o_de_alu_op = ALU_OR;
      OP_XOR:  o_de_alu_op = ALU_XOR;
      OP_LDI:  o_de_alu_op = ALU_OR;
      OP_SUB, OP_CMPEQ, OP_CMPNE, OP_CMPLT,
      OP_CMPLTU, OP_CMPGE, OP_CMPGEU: o_de_alu_op = ALU_SUB;
      default: o_de_alu_op = ALU_ADD;
    endcase
  end

  always_comb begin
    case (instr_q.r_form.opcode)
      OP_CMPNE:  o_de_cmp_op = CMP_NE;
      OP_CMPLT:  o_de_cmp_op = CMP_LT;
      OP_CMPLTU: o_de_cmp_op = CMP_LTU;
      OP_CMPGE:  o_de_cmp_op = CMP_GE;
      OP_CMPGEU: o_de_cmp_op = CMP_GEU;
      default:   o_de_cmp_op = CMP_EQ;
    endcase
  end

  // Pin instructions use the immediate view for op and index.
  always_comb o_de_pin_op    = pin_op_t'(instr_q.i_form.imm[3:2]);
  always_comb o_de_pin_idx   = instr_q.i_form.imm[1:0];
  always_comb o_de_cond_mask = instr_q.i_form.imm;

  // Strobes and register indices.
  // Nothing is strobed for a bubble or an unknown opcode.
  always_comb begin
    o_de_dst     = instr_q.r_form.dst;
    o_de_lhs     = instr_q.r_form.lhs;
    o_de_rhs     = instr_q.r_form.rhs;
    o_de_wr      = 1'b0;
    o_de_cmp     = 1'b0;
    o_de_cond_wr = 1'b0;
    o_de_pin     = 1'b0;
    is_ldi       = 1'b0;

    if (vld_q) begin
      case (instr_q.r_form.opcode)
        OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: begin
          o_de_wr = 1'b1;
        end
        OP_CMPEQ, OP_CMPNE, OP_CMPLT, OP_CMPLTU, OP_CMPGE, OP_CMPGEU: begin
          o_de_cmp = 1'b1;
        end
        OP_LDI: begin
          o_de_lhs = REG_ZR;
          o_de_rhs = REG_ZR;
          o_de_wr  = 1'b1;
          is_ldi   = 1'b1;
        end
        OP_COND: begin
          o_de_cond_wr = 1'b1;
        end
        OP_PIN: begin
          // The single register is read for OUT and written for IN.
          o_de_lhs = instr_q.i_form.dst;
          o_de_wr  = o_de_pin_op == PIN_IN;
          o_de_pin = 1'b1;
        end
        default: begin
          o_de_wr = 1'b0;
        end
      endcase
    end
  end

  // The immediate is zero extended, so only the two low slices carry it.
  // Outside LDI it is held at zero.
  always_comb begin
    o_de_imm = '0;
    if (is_ldi) begin
      case (ctr_q)
        2'd0:    o_de_imm = instr_q.i_form.imm[3:0];
        2'd1:    o_de_imm = instr_q.i_form.imm[7:4];
        default: o_de_imm = '0;
      endcase
    end
  end

endmodule

// File: hw/ex_regfile.sv
module ex_regfile (
  input  var logic            i_rf_gck,
  input  var ex_pkg::ctr_t    i_rf_ctr,

  input  var ex_pkg::reg_t    i_rf_lhs,
  input  var ex_pkg::reg_t    i_rf_rhs,
  output var ex_pkg::slice_t  o_rf_lhs_data,
  output var ex_pkg::slice_t  o_rf_rhs_data,

  input  var ex_pkg::reg_t    i_rf_dst,
  input  var logic            i_rf_dst_en,
  input  var ex_pkg::slice_t  i_rf_dst_data
);

  import ex_pkg::*;

  // Each register is kept as its slices so the counter selects one directly.
  slice_t regs_q [2**$bits(reg_t)][SLICES];

  // Reads are combinational for the current slice.
  // The zero register never comes from storage.
  always_comb begin
    o_rf_lhs_data = regs_q[i_rf_lhs][i_rf_ctr];
    if (i_rf_lhs == REG_ZR) begin
      o_rf_lhs_data = '0;
    end
  end

  always_comb begin
    o_rf_rhs_data = regs_q[i_rf_rhs][i_rf_ctr];
    if (i_rf_rhs == REG_ZR) begin
      o_rf_rhs_data = '0;
    end
  end

  // One slice lands per edge.
  // A write aimed at the zero register is dropped.
  always_ff @(posedge i_rf_gck) begin
    if (i_rf_dst_en && i_rf_dst != REG_ZR) begin
      regs_q[i_rf_dst][i_rf_ctr] <= i_rf_dst_data;
    end
  end

endmodule

// File: hw/ex_alu.sv
module ex_alu (
  input  var logic             i_alu_gck,
  input  var ex_pkg::ctr_t     i_alu_ctr,
  input  var ex_pkg::alu_op_t  i_alu_op,

  input  var ex_pkg::slice_t   i_alu_lhs,
  input  var ex_pkg::slice_t   i_alu_rhs,
  output var ex_pkg::slice_t   o_alu_out,

  output var logic             o_alu_z,
  output var logic             o_alu_n,
  output var logic             o_alu_c,
  output var logic             o_alu_v
);

  import ex_pkg::*;

  logic       first;
  slice_t     rhs_op;
  logic       cin;
  logic [4:0] sum;
  logic       carry_q;
  logic       zero_q;

  always_comb first = i_alu_ctr == '0;

  // Subtract is an add of the inverted operand.
  // The +1 enters as the carry into the first slice.
  always_comb rhs_op = i_alu_op == ALU_SUB ? ~i_alu_rhs : i_alu_rhs;
  always_comb cin    = first ? i_alu_op == ALU_SUB : carry_q;
  always_comb sum    = {1'b0, i_alu_lhs} + {1'b0, rhs_op} + {4'b0000, cin};

  always_comb begin
    case (i_alu_op)
      ALU_AND: o_alu_out = i_alu_lhs & i_alu_rhs;
      ALU_OR:  o_alu_out = i_alu_lhs | i_alu_rhs;
      ALU_XOR: o_alu_out = i_alu_lhs ^ i_alu_rhs;
      default: o_alu_out = sum[3:0];
    endcase
  end

  // Carry and the running zero pass from one slice to the next.
  // The first slice ignores whatever the previous word left behind.
  always_ff @(posedge i_alu_gck) begin
    carry_q <= sum[4];
    zero_q  <= o_alu_z;
  end

  // Flags describe the whole word once the last slice is on the inputs.
  // N, C and V come from that top slice, Z from all four.
  always_comb o_alu_z = (first || zero_q) && o_alu_out == '0;
  always_comb o_alu_n = o_alu_out[3];
  always_comb o_alu_c = sum[4];

  // Overflow when both addends share a sign that the result does not.
  always_comb o_alu_v = i_alu_lhs[3] == rhs_op[3] && sum[3] != i_alu_lhs[3];

endmodule

// File: hw/ex_cond.sv
module ex_cond (
  input  var logic             i_cd_gck,
  input  var logic             i_cd_rst_n,
  input  var ex_pkg::ctr_t     i_cd_ctr,
  input  var logic             i_cd_vld,

  input  var logic             i_cd_cmp,
  input  var ex_pkg::cmp_op_t  i_cd_cmp_op,
  input  var logic             i_cd_z,
  input  var logic             i_cd_n,
  input  var logic             i_cd_c,
  input  var logic             i_cd_v,

  input  var logic             i_cd_cond_wr,
  input  var ex_pkg::cond_t    i_cd_mask,

  output var logic             o_cd_skip,
  output var logic             o_cd_pred
);

  import ex_pkg::*;

  logic  last;
  logic  pred_d;
  logic  pred_q;
  cond_t mask_q;

  always_comb last = &i_cd_ctr;

  // Compare result from the flags of the final slice.
  always_comb begin
    case (i_cd_cmp_op)
      CMP_EQ:  pred_d = i_cd_z;
      CMP_NE:  pred_d = !i_cd_z;
      CMP_LT:  pred_d = i_cd_n != i_cd_v;
      CMP_LTU: pred_d = !i_cd_c;
      CMP_GE:  pred_d = i_cd_n == i_cd_v;
      default: pred_d = i_cd_c;
    endcase
  end

  // P and the mask change only at the end of a window.
  // Every real instruction consumes one mask bit, even a skipped one,
  // unless a COND that runs replaces the whole mask.
  always_ff @(posedge i_cd_gck, negedge i_cd_rst_n) begin
    if (!i_cd_rst_n) begin
      pred_q <= 1'b0;
      mask_q <= '0;
    end
    else if (last) begin
      if (i_cd_cmp) begin
        pred_q <= pred_d;
      end
      if (i_cd_vld) begin
        mask_q <= i_cd_cond_wr ? i_cd_mask : mask_q >> 1;
      end
    end
  end

  // The mask is live while a terminating bit sits above bit 0.
  // Bit 0 then names the value of P that lets the instruction run.
  always_comb o_cd_skip = |mask_q[7:1] && mask_q[0] != pred_q;
  always_comb o_cd_pred = pred_q;

endmodule

// File: hw/ex_pins.sv
module ex_pins (
  input  var logic             i_pn_gck,
  input  var logic             i_pn_rst_n,
  input  var ex_pkg::ctr_t     i_pn_ctr,

  input  var logic             i_pn_en,
  input  var ex_pkg::pin_op_t  i_pn_op,
  input  var logic [1:0]       i_pn_idx,
  input  var logic             i_pn_lhs0,
  input  var logic             i_pn_pred,

  input  var ex_pkg::pins_t    i_pn_pins,
  output var ex_pkg::slice_t   o_pn_data,
  output var ex_pkg::pins_t    o_pn_pins
);

  import ex_pkg::*;

  pins_t in_q;
  pins_t out_q;

  // Input pins are sampled on every edge.
  always_ff @(posedge i_pn_gck) begin
    in_q <= i_pn_pins;
  end

  // The pin bit rides in bit 0 of the first slice.
  // All higher slices are zero, so IN loads a clean 0 or 1.
  always_comb begin
    o_pn_data = '0;
    if (i_pn_ctr == '0) begin
      case (i_pn_op)
        PIN_IN:   o_pn_data = {3'b000, in_q[i_pn_idx]};
        PIN_OUT:  o_pn_data = {3'b000, i_pn_lhs0};
        PIN_OUTN: o_pn_data = {3'b000, !i_pn_lhs0};
        default:  o_pn_data = {3'b000, i_pn_pred};
      endcase
    end
  end

  // Output pins change at the end of the first slice.
  always_ff @(posedge i_pn_gck, negedge i_pn_rst_n) begin
    if (!i_pn_rst_n) begin
      out_q <= '0;
    end
    else if (i_pn_en && i_pn_ctr == '0 && i_pn_op != PIN_IN) begin
      out_q[i_pn_idx] <= o_pn_data[0];
    end
  end

  always_comb o_pn_pins = out_q;

endmodule

// File: hw/ex_core.sv
module ex_core (
  input  var logic           i_ex_gck,
  input  var logic           i_ex_rst_n,

  input  var ex_pkg::word_t  i_ex_enc,
  input  var logic           i_ex_enc_vld,
  output var logic           o_ex_enc_acp,

  input  var ex_pkg::pins_t  i_ex_io_pins,
  output var ex_pkg::pins_t  o_ex_io_pins
);

  import ex_pkg::*;

  ctr_t       ctr;
  alu_op_t    alu_op;
  cmp_op_t    cmp_op;
  pin_op_t    pin_op;
  logic [1:0] pin_idx;
  reg_t       dst;
  reg_t       lhs;
  reg_t       rhs;
  slice_t     imm;
  cond_t      cond_mask;

  // Raw strobes from the decoder and their versions after the skip.
  logic de_wr;
  logic de_cmp;
  logic de_cond_wr;
  logic de_pin;
  logic instr_vld;
  logic skip;
  logic rf_wr;
  logic cmp_run;
  logic cond_run;
  logic pin_run;

  slice_t lhs_data;
  slice_t rhs_data;
  slice_t alu_out;
  logic   alu_z;
  logic   alu_n;
  logic   alu_c;
  logic   alu_v;
  logic   pred;
  slice_t pin_data;
  slice_t dst_data;

  ex_decode u_ex_decode (
    .i_de_gck       (i_ex_gck),
    .i_de_rst_n     (i_ex_rst_n),
    .i_de_enc       (i_ex_enc),
    .i_de_enc_vld   (i_ex_enc_vld),
    .o_de_acp       (o_ex_enc_acp),
    .o_de_ctr       (ctr),
    .o_de_alu_op    (alu_op),
    .o_de_cmp_op    (cmp_op),
    .o_de_pin_op    (pin_op),
    .o_de_pin_idx   (pin_idx),
    .o_de_dst       (dst),
    .o_de_lhs       (lhs),
    .o_de_rhs       (rhs),
    .o_de_imm       (imm),
    .o_de_wr        (de_wr),
    .o_de_cmp       (de_cmp),
    .o_de_cond_wr   (de_cond_wr),
    .o_de_pin       (de_pin),
    .o_de_cond_mask (cond_mask)
  );

  // Every real instruction raises at least one strobe.
  // A window without any of them is a bubble and leaves the mask alone.
  always_comb instr_vld = de_wr || de_cmp || de_cond_wr || de_pin;

  // The skip suppresses every architectural effect of the instruction.
  always_comb rf_wr    = de_wr && !skip;
  always_comb cmp_run  = de_cmp && !skip;
  always_comb cond_run = de_cond_wr && !skip;
  always_comb pin_run  = de_pin && !skip;

  // Pin operations write the pin slice.
  // Otherwise the immediate merges onto the ALU result, as each side is
  // zero whenever the other one carries data.
  always_comb dst_data = de_pin ? pin_data : alu_out | imm;

  ex_regfile u_ex_regfile (
    .i_rf_gck      (i_ex_gck),
    .i_rf_ctr      (ctr),
    .i_rf_lhs      (lhs),
    .i_rf_rhs      (rhs),
    .o_rf_lhs_data (lhs_data),
    .o_rf_rhs_data (rhs_data),
    .i_rf_dst      (dst),
    .i_rf_dst_en   (rf_wr),
    .i_rf_dst_data (dst_data)
  );

  ex_alu u_ex_alu (
    .i_alu_gck (i_ex_gck),
    .i_alu_ctr (ctr),
    .i_alu_op  (alu_op),
    .i_alu_lhs (lhs_data),
    .i_alu_rhs (rhs_data),
    .o_alu_out (alu_out),
    .o_alu_z   (alu_z),
    .o_alu_n   (alu_n),
    .o_alu_c   (alu_c),
    .o_alu_v   (alu_v)
  );

  ex_cond u_ex_cond (
    .i_cd_gck     (i_ex_gck),
    .i_cd_rst_n   (i_ex_rst_n),
    .i_cd_ctr     (ctr),
    .i_cd_vld     (instr_vld),
    .i_cd_cmp     (cmp_run),
    .i_cd_cmp_op  (cmp_op),
    .i_cd_z       (alu_z),
    .i_cd_n       (alu_n),
    .i_cd_c       (alu_c),
    .i_cd_v       (alu_v),
    .i_cd_cond_wr (cond_run),
    .i_cd_mask    (cond_mask),
    .o_cd_skip    (skip),
    .o_cd_pred    (pred)
  );

  // OUT and OUTN look at bit 0 of the register on the first slice.
  ex_pins u_ex_pins (
    .i_pn_gck   (i_ex_gck),
    .i_pn_rst_n (i_ex_rst_n),
    .i_pn_ctr   (ctr),
    .i_pn_en    (pin_run),
    .i_pn_op    (pin_op),
    .i_pn_idx   (pin_idx),
    .i_pn_lhs0  (lhs_data[0]),
    .i_pn_pred  (pred),
    .i_pn_pins  (i_ex_io_pins),
    .o_pn_data  (pin_data),
    .o_pn_pins  (o_ex_io_pins)
  );

endmodule

// File: verif/ex_core_asserts.sv
module ex_core_asserts (
  input var logic          i_gck,
  input var logic          i_rst_n,
  input var logic          i_acp,
  input var ex_pkg::pins_t i_pins
);

  // Number of assertion failures seen so far.
  int fail_cnt = 0;

  // An accepted slot is followed by three quiet cycles and then the next slot.
  property acp_period;
    @(posedge i_gck) disable iff (!i_rst_n)
      i_acp |=> !i_acp ##1 !i_acp ##1 !i_acp ##1 i_acp;
  endproperty

  assert property (acp_period)
    else begin
      fail_cnt++;
      $error("o_ex_enc_acp did not recur after four cycles");
    end

  // The output pins stay cleared for as long as reset is held.
  assert property (@(posedge i_gck) !i_rst_n |-> i_pins == '0)
    else begin
      fail_cnt++;
      $error("o_ex_io_pins not zero during reset");
    end

endmodule

bind ex_core ex_core_asserts u_ex_core_asserts (
  .i_gck   (i_ex_gck),
  .i_rst_n (i_ex_rst_n),
  .i_acp   (o_ex_enc_acp),
  .i_pins  (o_ex_io_pins)
);

// File: verif/ex_core_tb.sv
module ex_core_tb;

  import ex_pkg::*;

  // No window lasts longer than four cycles, so this leaves ample margin.
  localparam int ACP_TIMEOUT = 16;

  logic  i_ex_gck;
  logic  i_ex_rst_n;
  word_t i_ex_enc;
  logic  i_ex_enc_vld;
  logic  o_ex_enc_acp;
  pins_t i_ex_io_pins;
  pins_t o_ex_io_pins;

  // Each row holds an encoding, the input pins driven with it, and the
  // output pins expected once its window has ended.
  word_t enc_tab [$];
  pins_t in_tab [$];
  pins_t exp_tab [$];

  // Running state while the table is built.
  pins_t       pins_in;
  pins_t       pins_exp;
  logic [31:0] lcg_state;

  ex_core u_ex_core (
    .i_ex_gck     (i_ex_gck),
    .i_ex_rst_n   (i_ex_rst_n),
    .i_ex_enc     (i_ex_enc),
    .i_ex_enc_vld (i_ex_enc_vld),
    .o_ex_enc_acp (o_ex_enc_acp),
    .i_ex_io_pins (i_ex_io_pins),
    .o_ex_io_pins (o_ex_io_pins)
  );

  initial begin
    i_ex_gck = 1'b0;
    forever #4 i_ex_gck = ~i_ex_gck;
  end

  // Linear congruential generator; the middle bits give the byte.
  function automatic logic [7:0] rand_byte();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[23:16];
  endfunction

  function automatic word_t enc_r(logic [3:0] op, reg_t dst, reg_t lhs, reg_t rhs);
    return {op, dst, lhs, rhs};
  endfunction

  function automatic word_t enc_i(logic [3:0] op, reg_t dst, logic [7:0] imm);
    return {op, dst, imm};
  endfunction

  task automatic push_row(word_t enc);
    enc_tab.push_back(enc);
    in_tab.push_back(pins_in);
    exp_tab.push_back(pins_exp);
  endtask

  // Every pin operation except IN drives the indexed output pin.
  task automatic add_pin(pin_op_t op, reg_t r, logic [1:0] idx, logic val);
    if (op != PIN_IN) begin
      pins_exp[idx] = val;
    end
    push_row(enc_i(OP_PIN, r, {4'h0, op, idx}));
  endtask

  task automatic report_failure();
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_value(string name, logic [15:0] got, logic [15:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp);
      report_failure();
    end
  endtask

  always @(negedge i_ex_gck) begin
    if (u_ex_core.u_ex_core_asserts.fail_cnt != 0) begin
      $display("A bound assertion on ex_core failed");
      report_failure();
    end
  end

  // Returns on the falling edge of a cycle in which the core accepts.
  task automatic wait_acp();
    int cycles;
    cycles = 0;
    @(negedge i_ex_gck);
    while (!o_ex_enc_acp) begin
      if (cycles == ACP_TIMEOUT) begin
        $display("Timed out waiting for o_ex_enc_acp");
        report_failure();
      end
      cycles++;
      @(negedge i_ex_gck);
    end
  endtask

  task automatic build_table();
    logic [7:0]  a;
    logic [7:0]  b;
    logic [15:0] x;
    logic [15:0] y;
    logic [3:0]  op;
    logic        res;
    int          i;
    pins_in  = '0;
    pins_exp = '0;
    // A no-op opens the run, so its check shows the pins as reset left them.
    push_row(enc_r(4'h0, REG_ZR, REG_ZR, REG_ZR));
    // LDI then OUT, once with each parity of bit 0.
    a = rand_byte();
    push_row(enc_i(OP_LDI, 4'd1, a));
    add_pin(PIN_OUT, 4'd1, 2'd0, a[0]);
    b = rand_byte();
    b[0] = ~a[0];
    push_row(enc_i(OP_LDI, 4'd2, b));
    add_pin(PIN_OUT, 4'd2, 2'd1, b[0]);
    // The operands are kept small so that the sum fits in one byte.
    a = rand_byte() & 8'h7f;
    b = rand_byte() & 8'h7f;
    push_row(enc_i(OP_LDI, 4'd1, a));
    push_row(enc_i(OP_LDI, 4'd2, b));
    push_row(enc_r(OP_ADD, 4'd3, 4'd1, 4'd2));
    push_row(enc_i(OP_LDI, 4'd4, a + b));
    push_row(enc_r(OP_CMPEQ, REG_ZR, 4'd3, 4'd4));
    add_pin(PIN_OUTP, REG_ZR, 2'd2, 1'b1);
    add_pin(PIN_OUTP, REG_ZR, 2'd3, 1'b1);
    // The minuend is above the subtrahend, so the difference stays positive.
    a = rand_byte() | 8'h80;
    b = rand_byte() & 8'h7f;
    push_row(enc_i(OP_LDI, 4'd1, a));
    push_row(enc_i(OP_LDI, 4'd2, b));
    push_row(enc_r(OP_SUB, 4'd5, 4'd1, 4'd2));
    push_row(enc_i(OP_LDI, 4'd6, (a - b) ^ 8'h01));
    push_row(enc_r(OP_CMPEQ, REG_ZR, 4'd5, 4'd6));
    add_pin(PIN_OUTP, REG_ZR, 2'd3, 1'b0);
    push_row(enc_i(OP_LDI, 4'd6, a - b));
    push_row(enc_r(OP_CMPEQ, REG_ZR, 4'd5, 4'd6));
    add_pin(PIN_OUTP, REG_ZR, 2'd3, 1'b1);
    // Operands are differences of random bytes, so either sign can occur.
    for (i = 0; i < 5; i++) begin
      a = rand_byte();
      b = rand_byte();
      x = {8'h00, a} - {8'h00, b};
      push_row(enc_i(OP_LDI, 4'd1, a));
      push_row(enc_i(OP_LDI, 4'd2, b));
      push_row(enc_r(OP_SUB, 4'd7, 4'd1, 4'd2));
      a = rand_byte();
      b = rand_byte();
      y = {8'h00, a} - {8'h00, b};
      push_row(enc_i(OP_LDI, 4'd1, a));
      push_row(enc_i(OP_LDI, 4'd2, b));
      push_row(enc_r(OP_SUB, 4'd8, 4'd1, 4'd2));
      case (i)
        0: begin
          op  = OP_CMPLT;
          res = $signed(x) < $signed(y);
        end
        1: begin
          op  = OP_CMPLTU;
          res = x < y;
        end
        2: begin
          op  = OP_CMPGE;
          res = $signed(x) >= $signed(y);
        end
        3: begin
          op  = OP_CMPGEU;
          res = x >= y;
        end
        default: begin
          op  = OP_CMPNE;
          res = x != y;
        end
      endcase
      push_row(enc_r(op, REG_ZR, 4'd7, 4'd8));
      add_pin(PIN_OUTP, REG_ZR, i[1:0], res);
    end
    // Bit 0 of a bitwise result depends only on bit 0 of the operands.
    a = rand_byte();
    b = rand_byte();
    push_row(enc_i(OP_LDI, 4'd1, a));
    push_row(enc_i(OP_LDI, 4'd2, b));
    push_row(enc_r(OP_AND, 4'd9, 4'd1, 4'd2));
    add_pin(PIN_OUT, 4'd9, 2'd0, a[0] & b[0]);
    push_row(enc_r(OP_OR, 4'd10, 4'd1, 4'd2));
    add_pin(PIN_OUTN, 4'd10, 2'd1, ~(a[0] | b[0]));
    push_row(enc_r(OP_XOR, 4'd11, 4'd1, 4'd2));
    add_pin(PIN_OUT, 4'd11, 2'd2, a[0] ^ b[0]);
    add_pin(PIN_OUTN, 4'd11, 2'd3, ~(a[0] ^ b[0]));
    // With mask 101 and P set the first OUT runs and the second is skipped.
    // The third runs again because the mask is spent by then.
    push_row(enc_i(OP_LDI, 4'd12, 8'h01));
    add_pin(PIN_OUT, REG_ZR, 2'd0, 1'b0);
    add_pin(PIN_OUT, REG_ZR, 2'd1, 1'b0);
    push_row(enc_r(OP_CMPEQ, REG_ZR, REG_ZR, REG_ZR));
    push_row(enc_i(OP_COND, REG_ZR, 8'h05));
    add_pin(PIN_OUT, 4'd12, 2'd0, 1'b1);
    push_row(enc_i(OP_PIN, 4'd12, {4'h0, PIN_OUT, 2'd1}));
    add_pin(PIN_OUT, 4'd12, 2'd1, 1'b1);
    // IN from pin 2 into a register, then OUT of that register to pin 3.
    for (i = 0; i < 2; i++) begin
      a = rand_byte();
      pins_in    = a[3:0];
      pins_in[2] = i[0];
      add_pin(PIN_IN, 4'd13, 2'd2, 1'b0);
      add_pin(PIN_OUT, 4'd13, 2'd3, pins_in[2]);
    end
  endtask

  initial begin
    int k;
    lcg_state    = 32'h1b90d535;
    i_ex_rst_n   = 1'b0;
    i_ex_enc     = '0;
    i_ex_enc_vld = 1'b0;
    i_ex_io_pins = '0;
    build_table();
    repeat (2) @(posedge i_ex_gck);
    @(negedge i_ex_gck);
    i_ex_rst_n = 1'b1;
    check_value("o_ex_io_pins", o_ex_io_pins, '0);
    check_value("o_ex_enc_acp", o_ex_enc_acp, 1'b0);
    // All effects of a row are visible at the acceptance that follows it.
    for (k = 0; k < enc_tab.size(); k++) begin
      wait_acp();
      if (k > 0) begin
        check_value("o_ex_io_pins", o_ex_io_pins, exp_tab[k - 1]);
      end
      i_ex_enc     = enc_tab[k];
      i_ex_enc_vld = 1'b1;
      i_ex_io_pins = in_tab[k];
    end
    wait_acp();
    check_value("o_ex_io_pins", o_ex_io_pins, exp_tab[enc_tab.size() - 1]);
    i_ex_enc_vld = 1'b0;
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

// File: ex_core.f
hw/ex_pkg.sv
hw/ex_decode.sv
hw/ex_regfile.sv
hw/ex_alu.sv
hw/ex_cond.sv
hw/ex_pins.sv
hw/ex_core.sv
verif/ex_core_asserts.sv
verif/ex_core_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f ex_core.f --top-module ex_core_tb
./obj_dir/Vex_core_tb > sim.log 2>&1 || true
cat sim.log
if grep -q "Simulation failed" sim.log; then
  echo "FAIL"
  exit 1
fi
if ! grep -q "Simulation completed successfully" sim.log; then
  echo "FAIL"
  exit 1
fi
echo "PASS"
